//--- include/x68_ctrl_cfg.svh
////////////////////
// X68000 system control configuration
// Default hold lengths and clock divider ratios
////////////////////

`ifndef X68_CTRL_CFG_SVH
`define X68_CTRL_CFG_SVH

// Floppy mount hold, about 16.7 million cycles
`define X68_MOUNT_HOLD 16777215

// Mount count above this reads as ejected
`define X68_MOUNT_EJECT_SPLIT 65535

// Eject request stretch
`define X68_EJECT_HOLD 65535

// Core reset hold after a hard-disk mount
`define X68_HDD_RESET_HOLD 65535

// Activity LED stretch
`define X68_LED_HOLD 4500000

// Sound and FM divide ratios
`define X68_SND_DIV 5
`define X68_FM_DIV 20

`endif

//--- design/x68_ctrl_pkg.sv
////////////////////
// X68000 system control types
// Counter, drive mask and synth info code types
////////////////////

package x68_ctrl_pkg;

	// Shared width of every hold timer
	typedef logic [23:0] hold_count_t;

	// One bit per virtual drive: floppy 0, floppy 1, hard disk, SRAM
	typedef logic [3:0] drive_mask_t;

	// Synth mode and ROM identifier as reported by the MIDI module
	typedef logic [7:0] synth_code_t;

	// On-screen info message index
	typedef enum logic [3:0] {
		INFO_SF0     = 4'd1,
		INFO_SF1     = 4'd2,
		INFO_SF2     = 4'd3,
		INFO_SF3     = 4'd4,
		INFO_SF4     = 4'd5,
		INFO_SF5     = 4'd6,
		INFO_SF6     = 4'd7,
		INFO_SF7     = 4'd8,
		INFO_MT32_V1 = 4'd9,
		INFO_MT32_V2 = 4'd10,
		INFO_CM32L   = 4'd11,
		INFO_UNKNOWN = 4'd12
	} info_code_e;

endpackage

//--- design/host_event_if.sv
////////////////////
// Host event bundle
// Single-cycle edge pulses from the host input side
////////////////////

`timescale 1ns/1ps

interface host_event_if import x68_ctrl_pkg::*; ();

	// First cycle of a download and first cycle after it
	logic        download_start;
	logic        download_end;

	// Falling edge of the menu reset
	logic        reset_release;

	// Rising edge of each image mount strobe
	drive_mask_t mount_rise;

	// Rising edge of the loader acknowledge
	logic        ack_rise;

	modport src (
		output download_start, download_end, reset_release, mount_rise, ack_rise
	);

	modport dst (
		input download_start, download_end, reset_release, mount_rise, ack_rise
	);

endinterface

//--- design/host_event_sync.sv
////////////////////
// Host event edge detector
// Registers host levels and emits one-cycle edge pulses
////////////////////

`timescale 1ns/1ps

module host_event_sync import x68_ctrl_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset_delayed,
	input  logic        ioctl_download,
	input  drive_mask_t img_mounted,
	input  logic        menu_reset,
	input  logic        ldr_ack,
	host_event_if.src   ev
);

	// Previous values of the host levels
	logic        download_d;
	drive_mask_t mounted_d;
	logic        menu_reset_d;
	logic        ack_d;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			download_d        <= 1'b0;
			mounted_d         <= '0;
			menu_reset_d      <= 1'b0;
			ack_d             <= 1'b0;
			ev.download_start <= 1'b0;
			ev.download_end   <= 1'b0;
			ev.reset_release  <= 1'b0;
			ev.mount_rise     <= '0;
			ev.ack_rise       <= 1'b0;
		end else begin
			download_d   <= ioctl_download;
			mounted_d    <= img_mounted;
			menu_reset_d <= menu_reset;
			ack_d        <= ldr_ack;

			// Pulses line up one cycle behind the input edge
			ev.download_start <= ioctl_download & ~download_d;
			ev.download_end   <= ~ioctl_download & download_d;
			ev.reset_release  <= ~menu_reset & menu_reset_d;
			ev.mount_rise     <= img_mounted & ~mounted_d;
			ev.ack_rise       <= ldr_ack & ~ack_d;
		end
	end

endmodule

//--- design/clock_enable_gen.sv
////////////////////
// Clock enable generator
// System, CPU, sound and FM enables with turbo CPU mode
////////////////////

`timescale 1ns/1ps
`include "x68_ctrl_cfg.svh"

module clock_enable_gen (
	input  logic       clk_sys,
	input  logic       reset_delayed,
	input  logic       turbo_req,
	input  logic       snd_clock_mode,
	output logic       sys_ce,
	output logic       cpu_ce_p,
	output logic       cpu_ce_n,
	output logic       snd_ce,
	output logic [1:0] opm_ce
);

	localparam int SND_DIV = `X68_SND_DIV;
	localparam int DEC_DIV = 2 * SND_DIV;
	localparam int FM_DIV  = `X68_FM_DIV;
	localparam int SND_W   = $clog2(SND_DIV);
	localparam int DEC_W   = $clog2(DEC_DIV);
	localparam int FM_W    = $clog2(FM_DIV);

	localparam logic [SND_W-1:0] SND_LAST = SND_W'(SND_DIV - 1);
	localparam logic [DEC_W-1:0] DEC_LAST = DEC_W'(DEC_DIV - 1);
	localparam logic [FM_W-1:0]  FM_LAST  = FM_W'(FM_DIV - 1);

	logic [1:0]       sys_div;
	logic [SND_W-1:0] snd_div;
	logic [DEC_W-1:0] dec_div;
	logic [FM_W-1:0]  fm_div;
	logic             turbo;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			sys_div  <= '0;
			snd_div  <= '0;
			dec_div  <= '0;
			fm_div   <= '0;
			turbo    <= 1'b0;
			sys_ce   <= 1'b0;
			cpu_ce_p <= 1'b0;
			cpu_ce_n <= 1'b0;
			snd_ce   <= 1'b0;
			opm_ce   <= '0;
		end else begin
			sys_div <= sys_div + 2'd1;
			snd_div <= (snd_div == SND_LAST) ? '0 : snd_div + 1'b1;
			dec_div <= (dec_div == DEC_LAST) ? '0 : dec_div + 1'b1;
			fm_div  <= (fm_div == FM_LAST) ? '0 : fm_div + 1'b1;

			// Turbo only switches on the system boundary
			if (&sys_div)
				turbo <= turbo_req;

			sys_ce   <= &sys_div;
			cpu_ce_p <= turbo ? sys_div[0] : (sys_div == 2'd3);
			cpu_ce_n <= turbo ? ~sys_div[0] : (sys_div == 2'd1);

			snd_ce    <= snd_clock_mode ? (dec_div == DEC_LAST) : (snd_div == SND_LAST);
			opm_ce[0] <= dec_div == DEC_LAST;
			opm_ce[1] <= fm_div == FM_LAST;
		end
	end

endmodule

//--- design/reset_sequencer.sv
////////////////////
// Core reset sequencer
// Joins reset sources and holds reset after a hard-disk mount
////////////////////

`timescale 1ns/1ps
`include "x68_ctrl_cfg.svh"

module reset_sequencer import x68_ctrl_pkg::*; #(
	parameter hold_count_t HOLD = hold_count_t'(`X68_HDD_RESET_HOLD)
) (
	input  logic      clk_sys,
	input  logic      reset_delayed,
	input  logic      button_reset,
	input  logic      menu_reset,
	host_event_if.dst ev,
	output logic      core_rstn
);

	logic        run_flag;
	logic        init_flag;
	hold_count_t hdd_hold;
	logic        reset_reg;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			run_flag  <= 1'b0;
			init_flag <= 1'b0;
			hdd_hold  <= '0;
			reset_reg <= 1'b1;
		end else begin
			// Core stays parked until the first download begins
			if (ev.download_start)
				run_flag <= 1'b1;
			if (ev.reset_release)
				init_flag <= 1'b1;

			if (ev.mount_rise[2])
				hdd_hold <= HOLD;
			else if (hdd_hold != '0)
				hdd_hold <= hdd_hold - 1'b1;

			reset_reg <= button_reset | menu_reset | ~init_flag | (hdd_hold != '0);
		end
	end

	assign core_rstn = run_flag & ~reset_reg;

endmodule

//--- design/disk_mount_timer.sv
////////////////////
// Disk mount timer
// Masks fresh floppy mounts as ejected and stretches eject requests
////////////////////

`timescale 1ns/1ps
`include "x68_ctrl_cfg.svh"

module disk_mount_timer import x68_ctrl_pkg::*; #(
	parameter hold_count_t MOUNT_HOLD        = hold_count_t'(`X68_MOUNT_HOLD),
	parameter hold_count_t MOUNT_EJECT_SPLIT = hold_count_t'(`X68_MOUNT_EJECT_SPLIT),
	parameter hold_count_t EJECT_HOLD        = hold_count_t'(`X68_EJECT_HOLD)
) (
	input  logic        clk_sys,
	input  logic        reset_delayed,
	input  logic [1:0]  fdd_eject_req,
	host_event_if.dst   ev,
	output drive_mask_t drive_mounted,
	output logic [1:0]  fdd_ejected
);

	hold_count_t mount_cnt [0:3];
	hold_count_t eject_cnt [0:1];

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			for (int i = 0; i < 4; i++)
				mount_cnt[i] <= '0;
			for (int i = 0; i < 2; i++)
				eject_cnt[i] <= '0;
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (ev.mount_rise[i])
					mount_cnt[i] <= MOUNT_HOLD;
				else if (mount_cnt[i] != '0)
					mount_cnt[i] <= mount_cnt[i] - 1'b1;
			end

			// Eject count reloads for as long as the request is held
			for (int i = 0; i < 2; i++) begin
				if (fdd_eject_req[i])
					eject_cnt[i] <= EJECT_HOLD;
				else if (eject_cnt[i] != '0)
					eject_cnt[i] <= eject_cnt[i] - 1'b1;
			end
		end
	end

	//////////////////////
	// Drive status flags

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			// Early part of the mount window looks like an empty drive
			fdd_ejected[i]   = (mount_cnt[i] > MOUNT_EJECT_SPLIT) | (eject_cnt[i] != '0);
			drive_mounted[i] = ~fdd_ejected[i] & (mount_cnt[i] != '0);
		end
		drive_mounted[2] = mount_cnt[2] != '0;
		drive_mounted[3] = mount_cnt[3] != '0;
	end

endmodule

//--- design/loader_bridge.sv
////////////////////
// Loader write bridge
// Host download writes to loader strobes, released by ack
////////////////////

`timescale 1ns/1ps

module loader_bridge (
	input  logic      clk_sys,
	input  logic      reset_delayed,
	input  logic      ioctl_download,
	input  logic      ioctl_wr,
	host_event_if.dst ev,
	output logic      ldr_wr,
	output logic      ldr_done,
	output logic      ldr_aen
);

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			ldr_wr   <= 1'b0;
			ldr_done <= 1'b0;
		end else begin
			// A new write wins over an ack in the same cycle
			if (ev.ack_rise & ldr_wr)
				ldr_wr <= 1'b0;
			if (ioctl_wr & ~ldr_done)
				ldr_wr <= 1'b1;

			// Only the first download goes to the loader
			if (ev.download_end)
				ldr_done <= 1'b1;
		end
	end

	assign ldr_aen = ioctl_download & ~ldr_done;

endmodule

//--- design/front_panel_status.sv
////////////////////
// Front panel status
// Hard-disk activity LED and MIDI synth info code
////////////////////

`timescale 1ns/1ps
`include "x68_ctrl_cfg.svh"

module front_panel_status import x68_ctrl_pkg::*; #(
	parameter hold_count_t LED_HOLD = hold_count_t'(`X68_LED_HOLD)
) (
	input  logic        clk_sys,
	input  logic        reset_delayed,
	input  logic        hdd_ack,
	input  logic        synth_newmode,
	input  logic [1:0]  info_mode,
	input  synth_code_t synth_mode,
	input  synth_code_t synth_rom,
	input  synth_code_t synth_sf,
	output logic        hdd_led,
	output logic        info_req,
	output info_code_e  info_disp
);

	hold_count_t led_cnt;
	logic        newmode_s;
	logic        newmode_d;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			led_cnt   <= '0;
			hdd_led   <= 1'b0;
			newmode_s <= 1'b0;
			newmode_d <= 1'b0;
			info_req  <= 1'b0;
		end else begin
			// Every ack restarts the stretch
			if (hdd_ack)
				led_cnt <= LED_HOLD;
			else if (led_cnt != '0)
				led_cnt <= led_cnt - 1'b1;
			hdd_led <= led_cnt != '0;

			newmode_s <= synth_newmode;
			newmode_d <= newmode_s;
			info_req  <= (newmode_s ^ newmode_d) && (info_mode == 2'd1);
		end
	end

	//////////////////////
	// Synth info message

	always_ff @(posedge clk_sys) begin
		if (synth_mode == 8'hA2)
			info_disp <= info_code_e'(4'd1 + {1'b0, synth_sf[2:0]});
		else if (synth_mode == 8'hA1) begin
			case (synth_rom)
				8'd0:    info_disp <= INFO_MT32_V1;
				8'd1:    info_disp <= INFO_MT32_V2;
				8'd2:    info_disp <= INFO_CM32L;
				default: info_disp <= INFO_UNKNOWN;
			endcase
		end else
			info_disp <= INFO_UNKNOWN;
	end

endmodule

//--- design/x68_ctrl_top.sv
////////////////////
// X68000 system control top level
// Clock enables, reset, disk mount, loader and front panel glue
////////////////////

`timescale 1ns/1ps
`include "x68_ctrl_cfg.svh"

module x68_ctrl_top import x68_ctrl_pkg::*; #(
	parameter hold_count_t MOUNT_HOLD        = hold_count_t'(`X68_MOUNT_HOLD),
	parameter hold_count_t MOUNT_EJECT_SPLIT = hold_count_t'(`X68_MOUNT_EJECT_SPLIT),
	parameter hold_count_t EJECT_HOLD        = hold_count_t'(`X68_EJECT_HOLD),
	parameter hold_count_t HDD_RESET_HOLD    = hold_count_t'(`X68_HDD_RESET_HOLD),
	parameter hold_count_t LED_HOLD          = hold_count_t'(`X68_LED_HOLD)
) (
	input  logic        clk_sys,
	input  logic        reset_delayed,
	input  logic        button_reset,
	input  logic        menu_reset,
	input  logic        turbo_req,
	input  logic        snd_clock_mode,
	input  logic        ioctl_download,
	input  logic        ioctl_wr,
	input  logic        ldr_ack,
	input  drive_mask_t img_mounted,
	input  logic [1:0]  fdd_eject_req,
	input  logic        hdd_ack,
	input  logic        synth_newmode,
	input  logic [1:0]  info_mode,
	input  synth_code_t synth_mode,
	input  synth_code_t synth_rom,
	input  synth_code_t synth_sf,

	output logic        sys_ce,
	output logic        cpu_ce_p,
	output logic        cpu_ce_n,
	output logic        snd_ce,
	output logic [1:0]  opm_ce,
	output logic        core_rstn,
	output drive_mask_t drive_mounted,
	output logic [1:0]  fdd_ejected,
	output logic        ldr_wr,
	output logic        ldr_done,
	output logic        ldr_aen,
	output logic        ioctl_wait,
	output logic        hdd_led,
	output logic        info_req,
	output info_code_e  info_disp
);

	host_event_if ev ();

	host_event_sync u_host_event_sync (
		.clk_sys        (clk_sys),
		.reset_delayed  (reset_delayed),
		.ioctl_download (ioctl_download),
		.img_mounted    (img_mounted),
		.menu_reset     (menu_reset),
		.ldr_ack        (ldr_ack),
		.ev             (ev.src)
	);

	clock_enable_gen u_clock_enable_gen (
		.clk_sys        (clk_sys),
		.reset_delayed  (reset_delayed),
		.turbo_req      (turbo_req),
		.snd_clock_mode (snd_clock_mode),
		.sys_ce         (sys_ce),
		.cpu_ce_p       (cpu_ce_p),
		.cpu_ce_n       (cpu_ce_n),
		.snd_ce         (snd_ce),
		.opm_ce         (opm_ce)
	);

	reset_sequencer #(
		.HOLD (HDD_RESET_HOLD)
	) u_reset_sequencer (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.button_reset  (button_reset),
		.menu_reset    (menu_reset),
		.ev            (ev.dst),
		.core_rstn     (core_rstn)
	);

	disk_mount_timer #(
		.MOUNT_HOLD        (MOUNT_HOLD),
		.MOUNT_EJECT_SPLIT (MOUNT_EJECT_SPLIT),
		.EJECT_HOLD        (EJECT_HOLD)
	) u_disk_mount_timer (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.fdd_eject_req (fdd_eject_req),
		.ev            (ev.dst),
		.drive_mounted (drive_mounted),
		.fdd_ejected   (fdd_ejected)
	);

	loader_bridge u_loader_bridge (
		.clk_sys        (clk_sys),
		.reset_delayed  (reset_delayed),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ev             (ev.dst),
		.ldr_wr         (ldr_wr),
		.ldr_done       (ldr_done),
		.ldr_aen        (ldr_aen)
	);

	// Host waits while a loader write is outstanding
	assign ioctl_wait = ldr_wr;

	front_panel_status #(
		.LED_HOLD (LED_HOLD)
	) u_front_panel_status (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.hdd_ack       (hdd_ack),
		.synth_newmode (synth_newmode),
		.info_mode     (info_mode),
		.synth_mode    (synth_mode),
		.synth_rom     (synth_rom),
		.synth_sf      (synth_sf),
		.hdd_led       (hdd_led),
		.info_req      (info_req),
		.info_disp     (info_disp)
	);

endmodule

//--- sim/x68_ctrl_tb.sv
////////////////////
// X68000 system control testbench
// Table-driven checks of enables, reset, loader, disk, synth and LED
////////////////////

`timescale 1ns/1ps
`include "x68_ctrl_cfg.svh"

module x68_ctrl_tb import x68_ctrl_pkg::*; ();

	localparam int RESET_CYCLES = 16;
	localparam int MAX_ROWS     = 96;

	// Row modes check a value at the end or count high cycles
	localparam int CHK = 0;
	localparam int CNT = 1;

	// Stimulus selectors
	localparam int IN_NONE = 0;
	localparam int IN_CE_MODE = 1;
	localparam int IN_MENU = 2;
	localparam int IN_BUTTON = 3;
	localparam int IN_DOWNLOAD = 4;
	localparam int IN_WR = 5;
	localparam int IN_ACK = 6;
	localparam int IN_IMG = 7;
	localparam int IN_EJECT = 8;
	localparam int IN_SYNTH = 9;
	localparam int IN_NEWMODE = 10;
	localparam int IN_INFO_MODE = 11;
	localparam int IN_HDD_ACK = 12;

	// Observed outputs
	localparam int OUT_NONE = 0;
	localparam int OUT_SYS = 1;
	localparam int OUT_CPU_P = 2;
	localparam int OUT_CPU_N = 3;
	localparam int OUT_SND = 4;
	localparam int OUT_OPM0 = 5;
	localparam int OUT_OPM1 = 6;
	localparam int OUT_RSTN = 7;
	localparam int OUT_LDR_WR = 8;
	localparam int OUT_WAIT = 9;
	localparam int OUT_DONE = 10;
	localparam int OUT_AEN = 11;
	localparam int OUT_MOUNT0 = 12;
	localparam int OUT_EJECT0 = 13;
	localparam int OUT_INFO_REQ = 14;
	localparam int OUT_DISP = 15;
	localparam int OUT_LED = 16;
	localparam int OUT_MOUNT2 = 17;

	logic        clk_sys;
	logic        reset_delayed;
	logic        button_reset;
	logic        menu_reset;
	logic        turbo_req;
	logic        snd_clock_mode;
	logic        ioctl_download;
	logic        ioctl_wr;
	logic        ldr_ack;
	drive_mask_t img_mounted;
	logic [1:0]  fdd_eject_req;
	logic        hdd_ack;
	logic        synth_newmode;
	logic [1:0]  info_mode;
	synth_code_t synth_mode;
	synth_code_t synth_rom;
	synth_code_t synth_sf;

	logic        sys_ce;
	logic        cpu_ce_p;
	logic        cpu_ce_n;
	logic        snd_ce;
	logic [1:0]  opm_ce;
	logic        core_rstn;
	drive_mask_t drive_mounted;
	logic [1:0]  fdd_ejected;
	logic        ldr_wr;
	logic        ldr_done;
	logic        ldr_aen;
	logic        ioctl_wait;
	logic        hdd_led;
	logic        info_req;
	info_code_e  info_disp;

	// Test table
	string row_name [0:MAX_ROWS-1];
	int    row_in_id [0:MAX_ROWS-1];
	int    row_in_val [0:MAX_ROWS-1];
	int    row_mode [0:MAX_ROWS-1];
	int    row_cycles [0:MAX_ROWS-1];
	int    row_out_id [0:MAX_ROWS-1];
	int    row_expected [0:MAX_ROWS-1];
	int    n_rows;
	int    total_cycles;

	int    checks;
	int    errors;
	int    cycle_count;
	int    timeout_limit;

	x68_ctrl_top #(
		.MOUNT_HOLD        (hold_count_t'(40)),
		.MOUNT_EJECT_SPLIT (hold_count_t'(30)),
		.EJECT_HOLD        (hold_count_t'(20)),
		.HDD_RESET_HOLD    (hold_count_t'(30)),
		.LED_HOLD          (hold_count_t'(25))
	) dut (.*);

	initial clk_sys = 1'b0;
	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count > timeout_limit) begin
			$display("Timeout: run did not finish within %0d cycles", timeout_limit);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic add_row(input string name, input int in_id, input int in_val,
		input int mode, input int cycles, input int out_id, input int expected);
		row_name[n_rows]     = name;
		row_in_id[n_rows]    = in_id;
		row_in_val[n_rows]   = in_val;
		row_mode[n_rows]     = mode;
		row_cycles[n_rows]   = cycles;
		row_out_id[n_rows]   = out_id;
		row_expected[n_rows] = expected;
		total_cycles += cycles;
		n_rows++;
	endtask

	task automatic build_table();
		//////////////////////
		// Clock enables over 40-cycle windows
		add_row("ce_mode_normal", IN_CE_MODE, 0, CHK, 8, OUT_NONE, 0);
		add_row("ce_sys_normal", IN_NONE, 0, CNT, 40, OUT_SYS, 10);
		add_row("ce_cpu_p_normal", IN_NONE, 0, CNT, 40, OUT_CPU_P, 10);
		add_row("ce_cpu_n_normal", IN_NONE, 0, CNT, 40, OUT_CPU_N, 10);
		add_row("ce_snd_mode0", IN_NONE, 0, CNT, 40, OUT_SND, 40 / `X68_SND_DIV);
		add_row("ce_opm0", IN_NONE, 0, CNT, 40, OUT_OPM0, 40 / (2 * `X68_SND_DIV));
		add_row("ce_opm1", IN_NONE, 0, CNT, 40, OUT_OPM1, 40 / `X68_FM_DIV);
		add_row("ce_mode_turbo", IN_CE_MODE, 2, CHK, 8, OUT_NONE, 0);
		add_row("ce_sys_turbo", IN_NONE, 0, CNT, 40, OUT_SYS, 10);
		add_row("ce_cpu_p_turbo", IN_NONE, 0, CNT, 40, OUT_CPU_P, 20);
		add_row("ce_cpu_n_turbo", IN_NONE, 0, CNT, 40, OUT_CPU_N, 20);
		add_row("ce_mode_snd1", IN_CE_MODE, 1, CHK, 8, OUT_NONE, 0);
		add_row("ce_cpu_p_snd1", IN_NONE, 0, CNT, 40, OUT_CPU_P, 10);
		add_row("ce_snd_mode1", IN_NONE, 0, CNT, 40, OUT_SND, 40 / (2 * `X68_SND_DIV));
		add_row("ce_mode_both", IN_CE_MODE, 3, CHK, 8, OUT_NONE, 0);
		add_row("ce_cpu_n_both", IN_NONE, 0, CNT, 40, OUT_CPU_N, 20);
		add_row("ce_snd_both", IN_NONE, 0, CNT, 40, OUT_SND, 40 / (2 * `X68_SND_DIV));

		//////////////////////
		// Reset sequencing
		add_row("rst_after_por", IN_NONE, 0, CHK, 4, OUT_RSTN, 0);
		add_row("rst_menu_on", IN_MENU, 1, CHK, 2, OUT_RSTN, 0);
		add_row("rst_menu_off", IN_MENU, 0, CHK, 4, OUT_RSTN, 0);
		add_row("rst_download", IN_DOWNLOAD, 1, CHK, 4, OUT_RSTN, 1);
		add_row("rst_button_on", IN_BUTTON, 1, CHK, 1, OUT_RSTN, 0);
		add_row("rst_button_off", IN_BUTTON, 0, CHK, 3, OUT_RSTN, 1);
		add_row("rst_hdd_mount", IN_IMG, 4, CHK, 1, OUT_NONE, 0);
		add_row("rst_hdd_hold", IN_IMG, 0, CHK, 9, OUT_RSTN, 0);
		add_row("rst_hdd_mounted", IN_NONE, 0, CHK, 0, OUT_MOUNT2, 1);
		add_row("rst_hdd_release", IN_NONE, 0, CHK, 26, OUT_RSTN, 1);

		//////////////////////
		// Loader bridge while the download is still active
		add_row("ldr_aen_on", IN_NONE, 0, CHK, 0, OUT_AEN, 1);
		add_row("ldr_wr_rise", IN_WR, 1, CHK, 1, OUT_LDR_WR, 1);
		add_row("ldr_wait_hold", IN_WR, 0, CHK, 3, OUT_WAIT, 1);
		add_row("ldr_ack_edge", IN_ACK, 1, CHK, 1, OUT_LDR_WR, 1);
		add_row("ldr_wr_fall", IN_NONE, 0, CHK, 1, OUT_LDR_WR, 0);
		add_row("ldr_wait_drop", IN_ACK, 0, CHK, 1, OUT_WAIT, 0);
		add_row("ldr_done_low", IN_NONE, 0, CHK, 0, OUT_DONE, 0);
		add_row("ldr_dl_end", IN_DOWNLOAD, 0, CHK, 1, OUT_DONE, 0);
		add_row("ldr_done_set", IN_NONE, 0, CHK, 1, OUT_DONE, 1);
		add_row("ldr_dl_again", IN_DOWNLOAD, 1, CHK, 2, OUT_AEN, 0);
		add_row("ldr_wr_ignored", IN_WR, 1, CHK, 1, OUT_LDR_WR, 0);
		add_row("ldr_wait_idle", IN_WR, 0, CHK, 2, OUT_WAIT, 0);
		add_row("ldr_dl_off", IN_DOWNLOAD, 0, CHK, 2, OUT_DONE, 1);

		//////////////////////
		// Floppy mount masking and eject stretch
		add_row("fdd_mount_pulse", IN_IMG, 1, CHK, 1, OUT_NONE, 0);
		add_row("fdd_masked", IN_IMG, 0, CHK, 4, OUT_EJECT0, 1);
		add_row("fdd_visible", IN_NONE, 0, CHK, 15, OUT_MOUNT0, 1);
		add_row("fdd_not_ejected", IN_NONE, 0, CHK, 0, OUT_EJECT0, 0);
		add_row("fdd_expired", IN_NONE, 0, CHK, 25, OUT_MOUNT0, 0);
		add_row("fdd_eject_req", IN_EJECT, 1, CHK, 1, OUT_EJECT0, 1);
		add_row("fdd_eject_hold", IN_EJECT, 0, CHK, 17, OUT_EJECT0, 1);
		add_row("fdd_eject_done", IN_NONE, 0, CHK, 6, OUT_EJECT0, 0);

		//////////////////////
		// Synth info with stimulus packed as {mode, rom, soundfont}
		add_row("info_sf0", IN_SYNTH, 'hA20000, CHK, 1, OUT_DISP, 1);
		add_row("info_sf5", IN_SYNTH, 'hA20005, CHK, 1, OUT_DISP, 6);
		add_row("info_sf7", IN_SYNTH, 'hA20007, CHK, 1, OUT_DISP, 8);
		add_row("info_mt32_v1", IN_SYNTH, 'hA10000, CHK, 1, OUT_DISP, 9);
		add_row("info_mt32_v2", IN_SYNTH, 'hA10100, CHK, 1, OUT_DISP, 10);
		add_row("info_cm32l", IN_SYNTH, 'hA10200, CHK, 1, OUT_DISP, 11);
		add_row("info_rom_other", IN_SYNTH, 'hA10300, CHK, 1, OUT_DISP, 12);
		add_row("info_mode_other", IN_SYNTH, 'h000003, CHK, 1, OUT_DISP, 12);
		add_row("info_mode_set1", IN_INFO_MODE, 1, CHK, 2, OUT_NONE, 0);
		add_row("info_req_rise", IN_NEWMODE, 1, CNT, 8, OUT_INFO_REQ, 1);
		add_row("info_req_fall", IN_NEWMODE, 0, CNT, 8, OUT_INFO_REQ, 1);
		add_row("info_mode_set0", IN_INFO_MODE, 0, CHK, 2, OUT_NONE, 0);
		add_row("info_req_mode0", IN_NEWMODE, 1, CNT, 8, OUT_INFO_REQ, 0);
		add_row("info_mode_set2", IN_INFO_MODE, 2, CHK, 2, OUT_NONE, 0);
		add_row("info_req_mode2", IN_NEWMODE, 0, CNT, 8, OUT_INFO_REQ, 0);

		//////////////////////
		// Activity LED stretch
		add_row("led_ack", IN_HDD_ACK, 1, CHK, 1, OUT_NONE, 0);
		add_row("led_on", IN_HDD_ACK, 0, CHK, 4, OUT_LED, 1);
		add_row("led_still_on", IN_NONE, 0, CHK, 15, OUT_LED, 1);
		add_row("led_off", IN_NONE, 0, CHK, 10, OUT_LED, 0);
		add_row("led_ack_first", IN_HDD_ACK, 1, CHK, 1, OUT_NONE, 0);
		add_row("led_gap", IN_HDD_ACK, 0, CHK, 19, OUT_LED, 1);
		add_row("led_ack_second", IN_HDD_ACK, 1, CHK, 1, OUT_LED, 1);
		add_row("led_held", IN_HDD_ACK, 0, CHK, 19, OUT_LED, 1);
		add_row("led_final_off", IN_NONE, 0, CHK, 10, OUT_LED, 0);
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic drive_input(input int id, input int value);
		logic [31:0] v;
		v = value;
		case (id)
			IN_CE_MODE: begin
				turbo_req      = v[1];
				snd_clock_mode = v[0];
			end
			IN_MENU:      menu_reset = v[0];
			IN_BUTTON:    button_reset = v[0];
			IN_DOWNLOAD:  ioctl_download = v[0];
			IN_WR:        ioctl_wr = v[0];
			IN_ACK:       ldr_ack = v[0];
			IN_IMG:       img_mounted = v[3:0];
			IN_EJECT:     fdd_eject_req = v[1:0];
			IN_SYNTH: begin
				synth_mode = v[23:16];
				synth_rom  = v[15:8];
				synth_sf   = v[7:0];
			end
			IN_NEWMODE:   synth_newmode = v[0];
			IN_INFO_MODE: info_mode = v[1:0];
			IN_HDD_ACK:   hdd_ack = v[0];
			default: ;
		endcase
	endtask

	function automatic logic [31:0] sample_out(input int id);
		case (id)
			OUT_SYS:      return {31'b0, sys_ce};
			OUT_CPU_P:    return {31'b0, cpu_ce_p};
			OUT_CPU_N:    return {31'b0, cpu_ce_n};
			OUT_SND:      return {31'b0, snd_ce};
			OUT_OPM0:     return {31'b0, opm_ce[0]};
			OUT_OPM1:     return {31'b0, opm_ce[1]};
			OUT_RSTN:     return {31'b0, core_rstn};
			OUT_LDR_WR:   return {31'b0, ldr_wr};
			OUT_WAIT:     return {31'b0, ioctl_wait};
			OUT_DONE:     return {31'b0, ldr_done};
			OUT_AEN:      return {31'b0, ldr_aen};
			OUT_MOUNT0:   return {31'b0, drive_mounted[0]};
			OUT_MOUNT2:   return {31'b0, drive_mounted[2]};
			OUT_EJECT0:   return {31'b0, fdd_ejected[0]};
			OUT_INFO_REQ: return {31'b0, info_req};
			OUT_DISP:     return {28'b0, info_disp};
			OUT_LED:      return {31'b0, hdd_led};
			default:      return 32'b0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// Inputs change now and outputs are read 1 ns after each later edge
	task automatic run_row(input int r);
		logic [31:0] count;
		count = 0;
		drive_input(row_in_id[r], row_in_val[r]);
		repeat (row_cycles[r]) begin
			next_cycle();
			count = count + sample_out(row_out_id[r]);
		end
		if (row_mode[r] == CNT)
			check_value(row_name[r], row_expected[r], count);
		else if (row_out_id[r] != OUT_NONE)
			check_value(row_name[r], row_expected[r], sample_out(row_out_id[r]));
	endtask

	initial begin
		reset_delayed  = 1'b1;
		button_reset   = 1'b0;
		menu_reset     = 1'b0;
		turbo_req      = 1'b0;
		snd_clock_mode = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ldr_ack        = 1'b0;
		img_mounted    = '0;
		fdd_eject_req  = '0;
		hdd_ack        = 1'b0;
		synth_newmode  = 1'b0;
		info_mode      = '0;
		synth_mode     = '0;
		synth_rom      = '0;
		synth_sf       = '0;
		checks         = 0;
		errors         = 0;
		cycle_count    = 0;
		n_rows         = 0;
		total_cycles   = 0;

		build_table();
		timeout_limit = RESET_CYCLES + total_cycles + 100;

		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		// Enables, loader, status flags and core reset all low in reset
		check_value("reset_state", 32'd0, {ldr_wr, ldr_done, sys_ce, cpu_ce_p, cpu_ce_n,
			snd_ce, opm_ce, hdd_led, info_req, drive_mounted, fdd_ejected, core_rstn});
		reset_delayed = 1'b0;

		for (int r = 0; r < n_rows; r++)
			run_row(r);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- sources.f
+incdir+include
design/x68_ctrl_pkg.sv
design/host_event_if.sv
design/host_event_sync.sv
design/clock_enable_gen.sv
design/reset_sequencer.sv
design/disk_mount_timer.sv
design/loader_bridge.sv
design/front_panel_status.sv
design/x68_ctrl_top.sv
sim/x68_ctrl_tb.sv
